// File: verilog/money_pkg.sv
package money_pkg;

	// Screen geometry in pixels
	localparam int unsigned SCREEN_W = 640;
	localparam int unsigned SCREEN_H = 480;

	// Bar placement
	localparam int unsigned BAR_WIDTH = 16; // Columns per bar
	localparam int unsigned BASE_Y = 400; // Bottom row of every bar
	localparam int unsigned P1_X = 80; // Left column, player one
	localparam int unsigned P2_X = 560; // Left column, player two

	// Bar colours as 3-bit RGB
	localparam logic [2:0] P1_COLOUR = 3'b010; // Green
	localparam logic [2:0] P2_COLOUR = 3'b100; // Red

	localparam int unsigned FB_AW = 19; // Frame buffer word address width

	// Host register map
	localparam logic [1:0] REG_LOW = 2'd0; // Balance bits 31:0
	localparam logic [1:0] REG_HIGH = 2'd1; // Balance bits 47:32
	localparam logic [1:0] REG_CTRL = 2'd2; // Draw on write, busy on read

	typedef struct packed {
		logic [9:0] x;
		logic [8:0] y;
		logic [2:0] colour;
	} pixel_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [1:0] adr;
		logic [31:0] dat;
	} host_req_t;

	typedef struct packed {
		logic ack;
		logic [31:0] dat;
	} host_rsp_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [FB_AW-1:0] adr;
		logic [2:0] dat;
	} fb_req_t;

endpackage

// File: verilog/balance_regs.sv
`timescale 1ns/10ps

module balance_regs (
	input logic clk,
	input logic rst_n,
	input money_pkg::host_req_t host_req,
	output money_pkg::host_rsp_t host_rsp,
	input logic busy,
	output logic draw,
	output logic [47:0] balance
);
	import money_pkg::*;

	logic ack_q; // Single-cycle Wishbone ack
	logic draw_q; // Draw request pulse
	logic req_hit; // New access seen this cycle
	logic wr_hit; // New write access
	logic draw_hit; // Accepted draw command
	logic status; // Busy as seen by the host
	logic [31:0] low_q; // Balance bits 31:0
	logic [15:0] high_q; // Balance bits 47:32
	logic [31:0] rdata_q; // Read data, valid with ack
	logic [31:0] rdata; // Read mux

	assign req_hit = host_req.cyc & host_req.stb & ~ack_q; // Ack only once per access
	assign wr_hit = req_hit & host_req.we;
	assign status = busy | draw_q; // Cover the gap before active rises

	// Draw only from an idle display, extra requests are dropped
	assign draw_hit = wr_hit & (host_req.adr == REG_CTRL) & host_req.dat[0] & ~status;

	always_comb begin
		case (host_req.adr)
			REG_LOW: rdata = low_q;
			REG_HIGH: rdata = {16'h0000, high_q};
			REG_CTRL: rdata = {31'd0, status};
			default: rdata = 32'd0; // Unmapped address
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
			draw_q <= 1'b0;
		end else begin
			ack_q <= req_hit;
			draw_q <= draw_hit; // One cycle wide, aligned with ack
		end
	end

	// Balance words and read data
	always_ff @(posedge clk) begin
		if (wr_hit && host_req.adr == REG_LOW) begin
			low_q <= host_req.dat;
		end
		if (wr_hit && host_req.adr == REG_HIGH) begin
			high_q <= host_req.dat[15:0]; // Upper half ignored
		end
		if (req_hit) begin
			rdata_q <= rdata; // Capture with the access
		end
	end

	assign host_rsp.ack = ack_q;
	assign host_rsp.dat = rdata_q;
	assign draw = draw_q;
	assign balance = {high_q, low_q};

	// Classic master holds cyc and stb through the ack cycle
	a_ack_in_cycle: assert property (
		@(posedge clk) disable iff (!rst_n)
		ack_q |-> host_req.cyc && host_req.stb
	) else $error("balance_regs: ack outside a bus cycle");

endmodule

// File: verilog/bar_graph_display.sv
`timescale 1ns/10ps

module bar_graph_display (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic [9:0] start_x,
	input logic [7:0] graph_height,
	input logic [2:0] colour,
	output money_pkg::pixel_t pix,
	output logic pix_valid,
	input logic pix_ready,
	output logic done
);
	import money_pkg::*;

	localparam logic [3:0] COL_LAST = 4'(BAR_WIDTH - 1); // Rightmost column offset

	logic running_q; // Walking a bar
	logic done_q; // Completion pulse
	logic [3:0] col_q; // Column offset in the bar
	logic [7:0] row_q; // Rows above the baseline
	logic [9:0] x_q; // Left column of the bar
	logic [7:0] h_q; // Bar height in rows
	logic [2:0] colour_q; // Bar colour
	logic xfer; // Pixel accepted downstream
	logic last_col; // End of a row
	logic last_row; // Top row of the bar

	assign xfer = running_q & pix_ready;
	assign last_col = (col_q == COL_LAST);
	assign last_row = (row_q == h_q - 8'd1); // h_q nonzero while running

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			running_q <= 1'b0;
			done_q <= 1'b0;
			col_q <= 4'd0;
			row_q <= 8'd0;
		end else begin
			done_q <= 1'b0; // Pulse by default
			if (start) begin
				col_q <= 4'd0;
				row_q <= 8'd0;
				running_q <= (graph_height != 8'd0);
				done_q <= (graph_height == 8'd0); // Empty bar ends at once
			end else if (xfer) begin
				if (last_col) begin
					col_q <= 4'd0;
					if (last_row) begin
						running_q <= 1'b0;
						done_q <= 1'b1; // Last pixel gone
					end else begin
						row_q <= row_q + 8'd1; // Next row up
					end
				end else begin
					col_q <= col_q + 4'd1;
				end
			end
		end
	end

	// Bar parameters captured at start
	always_ff @(posedge clk) begin
		if (start) begin
			x_q <= start_x;
			h_q <= graph_height;
			colour_q <= colour;
		end
	end

	// Pixel held from registers until taken
	assign pix.x = x_q + 10'(col_q);
	assign pix.y = 9'(BASE_Y) - 9'(row_q); // Screen y grows downward
	assign pix.colour = colour_q;
	assign pix_valid = running_q;
	assign done = done_q;

	// Placement plus height must stay on the screen
	a_pix_on_screen: assert property (
		@(posedge clk) disable iff (!rst_n)
		pix_valid |-> (32'(pix.x) < SCREEN_W) && (32'(pix.y) < SCREEN_H)
	) else $error("bar_graph_display: pixel off screen");

endmodule

// File: verilog/money_display.sv
`timescale 1ns/10ps

module money_display (
	input logic clk,
	input logic rst_n,
	input logic draw,
	input logic [47:0] balance,
	output money_pkg::pixel_t pix,
	output logic pix_valid,
	input logic pix_ready,
	output logic active
);
	import money_pkg::*;

	logic active_q; // Draw in progress
	logic phase_q; // 0 player one, 1 player two
	logic start1_q; // Kick off player one's bar
	logic [7:0] p1_h_q; // Player one balance snapshot
	logic [7:0] p2_h_q; // Player two balance snapshot
	logic draw_ok; // Draw accepted
	pixel_t p1_pix, p2_pix;
	logic p1_valid, p2_valid;
	logic p1_done, p2_done;

	assign draw_ok = draw & ~active_q; // Ignore draws mid-frame

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active_q <= 1'b0;
			phase_q <= 1'b0;
			start1_q <= 1'b0;
		end else begin
			start1_q <= draw_ok;
			if (draw_ok) begin
				active_q <= 1'b1;
				phase_q <= 1'b0;
			end
			if (p1_done) begin
				phase_q <= 1'b1; // Hand over to player two
			end
			if (p2_done) begin
				active_q <= 1'b0; // Last pixel accepted
			end
		end
	end

	always_ff @(posedge clk) begin
		if (draw_ok) begin
			p1_h_q <= balance[31:24];
			p2_h_q <= balance[7:0];
		end
	end

	bar_graph_display p1_bar (
		.clk (clk),
		.rst_n (rst_n),
		.start (start1_q),
		.start_x (10'(P1_X)),
		.graph_height (p1_h_q),
		.colour (P1_COLOUR),
		.pix (p1_pix),
		.pix_valid (p1_valid),
		.pix_ready (pix_ready & ~phase_q),
		.done (p1_done)
	);

	bar_graph_display p2_bar (
		.clk (clk),
		.rst_n (rst_n),
		.start (p1_done), // Second bar follows the first
		.start_x (10'(P2_X)),
		.graph_height (p2_h_q),
		.colour (P2_COLOUR),
		.pix (p2_pix),
		.pix_valid (p2_valid),
		.pix_ready (pix_ready & phase_q),
		.done (p2_done)
	);

	// Route whichever walker owns the phase
	assign pix = phase_q ? p2_pix : p1_pix;
	assign pix_valid = phase_q ? p2_valid : p1_valid;
	assign active = active_q;

	// The idle walker must never hold a pixel
	a_one_walker: assert property (
		@(posedge clk) disable iff (!rst_n)
		phase_q ? !p1_valid : !p2_valid
	) else $error("money_display: both walkers emitting");

endmodule

// File: verilog/pixel_writer.sv
`timescale 1ns/10ps

module pixel_writer (
	input logic clk,
	input logic rst_n,
	input money_pkg::pixel_t pix,
	input logic pix_valid,
	output logic pix_ready,
	output money_pkg::fb_req_t fb_req,
	input logic fb_ack,
	output logic busy
);
	import money_pkg::*;

	logic full_q; // Holding one pixel
	logic [FB_AW-1:0] adr_q; // Frame buffer word address
	logic [2:0] colour_q; // Write data
	logic [FB_AW-1:0] pix_adr; // Address of the incoming pixel
	logic xfer; // Pixel taken from the renderer

	assign pix_ready = ~full_q; // One write outstanding at most
	assign xfer = pix_valid & pix_ready;

	// Row-major frame buffer
	assign pix_adr = FB_AW'(pix.y) * FB_AW'(SCREEN_W) + FB_AW'(pix.x);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			full_q <= 1'b0;
		end else begin
			if (xfer) begin
				full_q <= 1'b1; // Bus cycle starts next cycle
			end else if (fb_ack) begin
				full_q <= 1'b0; // Drop after ack
			end
		end
	end

	always_ff @(posedge clk) begin
		if (xfer) begin
			adr_q <= pix_adr;
			colour_q <= pix.colour;
		end
	end

	// Single write per pixel
	assign fb_req.cyc = full_q;
	assign fb_req.stb = full_q;
	assign fb_req.we = full_q;
	assign fb_req.adr = adr_q;
	assign fb_req.dat = colour_q;
	assign busy = full_q;

	// Renderer keeps its pixel while the writer is full
	a_pix_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		pix_valid && !pix_ready |=> pix_valid && $stable(pix)
	) else $error("pixel_writer: pixel changed before transfer");

endmodule

// File: verilog/money_display_top.sv
`timescale 1ns/10ps

module money_display_top (
	input logic clk,
	input logic rst_n,
	input money_pkg::host_req_t host_req,
	output money_pkg::host_rsp_t host_rsp,
	output money_pkg::fb_req_t fb_req,
	input logic fb_ack
);
	import money_pkg::*;

	logic draw; // Draw request pulse
	logic [47:0] balance; // Both balances
	logic active; // Renderer busy
	logic wr_busy; // Writer holds a pixel
	pixel_t pix; // Renderer to writer
	logic pix_valid, pix_ready;

	balance_regs i_balance_regs (
		.clk (clk),
		.rst_n (rst_n),
		.host_req (host_req),
		.host_rsp (host_rsp),
		.busy (active | wr_busy), // Busy until the last write completes
		.draw (draw),
		.balance (balance)
	);

	money_display i_money_display (
		.clk (clk),
		.rst_n (rst_n),
		.draw (draw),
		.balance (balance),
		.pix (pix),
		.pix_valid (pix_valid),
		.pix_ready (pix_ready),
		.active (active)
	);

	pixel_writer i_pixel_writer (
		.clk (clk),
		.rst_n (rst_n),
		.pix (pix),
		.pix_valid (pix_valid),
		.pix_ready (pix_ready),
		.fb_req (fb_req),
		.fb_ack (fb_ack),
		.busy (wr_busy)
	);

endmodule

// File: tests/money_display_tb.sv
`timescale 1ns/10ps

module money_display_tb;
	import money_pkg::*;

	localparam int TRACE_WORDS = 64; // Room for 16 draws
	localparam int BUS_TIMEOUT = 20; // Cycles to wait for a host ack
	localparam int POLL_LIMIT = 40000; // Busy polls per draw

	logic clk;
	logic rst_n;
	host_req_t host_req;
	host_rsp_t host_rsp;
	fb_req_t fb_req;
	logic fb_ack;

	logic [31:0] trace [0:TRACE_WORDS-1]; // Four words per draw
	logic [FB_AW-1:0] exp_adr [$]; // Model pixel stream, addresses
	logic [2:0] exp_col [$]; // Model pixel stream, colours
	int mismatches;
	int failures;
	int pix_count; // Writes seen in the current draw
	logic [31:0] adr_sum; // Address sum of the current draw
	bit hung; // Some wait ran out

	money_display_top i_money_display_top (
		.clk (clk),
		.rst_n (rst_n),
		.host_req (host_req),
		.host_rsp (host_rsp),
		.fb_req (fb_req),
		.fb_ack (fb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	// One Wishbone classic access, held until ack
	task automatic bus_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int waited;
		waited = 0;
		@(posedge clk);
		host_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		@(negedge clk);
		while (!host_rsp.ack && waited < BUS_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!host_rsp.ack) begin
			$display("Error at %0t: no host ack at address %0d", $time, adr);
			failures++;
			hung = 1'b1;
		end
		rdat = host_rsp.dat; // Valid with ack
		@(posedge clk);
		host_req <= '0;
	endtask

	task automatic write_reg(input logic [1:0] adr, input logic [31:0] wdat);
		logic [31:0] ignored;
		bus_access(1'b1, adr, wdat, ignored);
	endtask

	task automatic read_check(input logic [1:0] adr, input logic [31:0] expected, input string what);
		logic [31:0] rdat;
		bus_access(1'b0, adr, 32'd0, rdat);
		if (!hung && rdat !== expected) begin
			$display("mismatch at %0t: %s read %h, expected %h", $time, what, rdat, expected);
			mismatches++;
		end
	endtask

	// Poll the control register until the display is idle
	task automatic wait_idle();
		logic [31:0] rdat;
		int polls;
		polls = 0;
		rdat = 32'd1;
		while (rdat[0] && !hung && polls < POLL_LIMIT) begin
			bus_access(1'b0, REG_CTRL, 32'd0, rdat);
			polls++;
		end
		if (rdat[0] && !hung) begin
			$display("Error at %0t: display still busy after %0d polls", $time, polls);
			failures++;
			hung = 1'b1;
		end else if (!hung && rdat !== 32'd0) begin
			$display("mismatch at %0t: idle status read %h, expected 0", $time, rdat);
			mismatches++;
		end
	endtask

	// Rows from the baseline upward, columns left to right
	task automatic push_bar(input int x0, input int h, input logic [2:0] col);
		for (int r = 0; r < h; r++) begin
			for (int c = 0; c < 16; c++) begin
				exp_adr.push_back(FB_AW'((400 - r) * 640 + x0 + c));
				exp_col.push_back(col);
			end
		end
	endtask

	function automatic void take_pixel(input logic [FB_AW-1:0] adr, input logic [2:0] dat);
		logic [FB_AW-1:0] e_adr;
		logic [2:0] e_col;
		if (exp_adr.size() == 0) begin
			$display("Error at %0t: write to %0d with no pixel left in the model", $time, adr);
			failures++;
		end else begin
			e_adr = exp_adr.pop_front();
			e_col = exp_col.pop_front();
			if (adr !== e_adr || dat !== e_col) begin
				$display("mismatch at %0t: pixel %0d wrote adr %0d col %b, expected adr %0d col %b",
					$time, pix_count, adr, dat, e_adr, e_col);
				mismatches++;
			end
		end
		pix_count++;
		adr_sum = adr_sum + 32'(adr);
	endfunction

	// Frame buffer stand-in with 0 to 3 cycles of ack delay
	initial begin
		logic [FB_AW-1:0] adr;
		logic [2:0] dat;
		int delay;
		fb_ack = 1'b0;
		void'($urandom(32'hed33)); // Single seed for the run
		forever begin
			@(negedge clk);
			if (fb_req.cyc && fb_req.stb) begin
				adr = fb_req.adr; // Held for the whole cycle
				dat = fb_req.dat;
				if (!fb_req.we) begin
					$display("Error at %0t: frame-buffer access is a read", $time);
					failures++;
				end
				delay = int'($urandom % 4);
				for (int d = 0; d < delay; d++) begin
					@(negedge clk);
					if (!(fb_req.cyc && fb_req.stb)) begin
						$display("Error at %0t: frame-buffer request dropped before ack", $time);
						failures++;
					end else if (fb_req.adr !== adr || fb_req.dat !== dat) begin
						$display("mismatch at %0t: request changed while waiting for ack", $time);
						mismatches++;
					end
				end
				@(posedge clk);
				fb_ack <= 1'b1;
				@(posedge clk);
				fb_ack <= 1'b0; // One-cycle ack
				take_pixel(adr, dat);
			end
		end
	end

	initial begin
		logic [31:0] low, high, exp_cnt, exp_sum;
		int p1, p2, n;
		rst_n = 1'b0;
		host_req = '0;
		mismatches = 0;
		failures = 0;
		hung = 1'b0;
		pix_count = 0;
		adr_sum = 32'd0;
		for (int k = 0; k < TRACE_WORDS; k++) begin
			trace[k] = ~32'(k); // Unused slots keep their inverted index
		end
		$readmemh("tests/money_display_trace.txt", trace);
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		read_check(2'd3, 32'd0, "unmapped address");
		n = 0;
		while (n < TRACE_WORDS / 4 && trace[4*n+2] != ~32'(4*n+2) && !hung) begin
			low = trace[4*n];
			high = trace[4*n+1];
			exp_cnt = trace[4*n+2];
			exp_sum = trace[4*n+3];
			p1 = int'(low[31:24]); // Player one byte
			p2 = int'(low[7:0]); // Player two byte
			push_bar(80, p1, 3'b010);
			push_bar(560, p2, 3'b100);
			pix_count = 0;
			adr_sum = 32'd0;
			write_reg(REG_LOW, low);
			write_reg(REG_HIGH, high);
			read_check(REG_LOW, low, "REG_LOW");
			read_check(REG_HIGH, {16'h0000, high[15:0]}, "REG_HIGH");
			write_reg(REG_CTRL, 32'd1);
			read_check(REG_CTRL, 32'd1, "busy after draw");
			write_reg(REG_CTRL, 32'd1); // Draw while busy, dropped
			wait_idle();
			if (!hung) begin
				if (32'(pix_count) !== exp_cnt || pix_count != 16 * (p1 + p2)) begin
					$display("mismatch at %0t: draw %0d wrote %0d pixels, expected %0d",
						$time, n, pix_count, exp_cnt);
					mismatches++;
				end
				if (adr_sum !== exp_sum) begin
					$display("mismatch at %0t: draw %0d address sum %h, expected %h",
						$time, n, adr_sum, exp_sum);
					mismatches++;
				end
				if (exp_adr.size() != 0) begin
					$display("Error at %0t: %0d model pixels never written", $time, exp_adr.size());
					failures++;
				end
			end
			exp_adr.delete();
			exp_col.delete();
			n++;
		end
		if (n == 0) begin
			$display("Error at %0t: trace file holds no draws", $time);
			failures++;
		end
		$display("Draws %0d, mismatches %0d, other errors %0d", n, mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: tests/money_display_trace.txt
// Columns: low word, high word, expected pixel count, expected address sum, all hex
// Player one is low word bits 31:24, player two is bits 7:0
03A55A05 00001234 00000080 01F2B9C0
00FFFF04 ABCD0001 00000040 00F99DE0 // Player one empty
07000000 00000000 00000070 01B25E48 // Player two empty
FF000000 0000FFFF 00000FF0 2A82CA88 // Full bar, player one
001234FF 5555AAAA 00000FF0 2AA0AC88 // Full bar, player two
00ABCD00 00000042 00000000 00000000 // Both bars empty
01000001 00000000 00000020 007D28F0
FF7788FF 00000F0F 00001FE0 55237710 // Both bars full
12C33CC8 00008001 00000DA0 2917D030

// File: project.f
verilog/money_pkg.sv
verilog/balance_regs.sv
verilog/bar_graph_display.sv
verilog/money_display.sv
verilog/pixel_writer.sv
verilog/money_display_top.sv
tests/money_display_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= money_display_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)

check: run
	@grep -q "^Finished with no errors$$" $(LOG) && echo "PASS" || \
		(echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
